/* logic/mem_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_controller import riscv_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    // Request side, credit based
    input  logic     req_valid_i,
    input  mem_req_t req_i,
    output logic     credit_o,
    // Response side
    output logic     rsp_valid_o,
    output mem_rsp_t rsp_o
);

    // Stages before the array access, the access itself is the last stage
    localparam int PIPE_DEPTH = MC_LATENCY - 1;

    // Word storage, contents undefined after reset
    data_t    mem_q [MEM_WORDS];

    logic     pipe_vld_q [PIPE_DEPTH];
    mem_req_t pipe_req_q [PIPE_DEPTH];

    logic     tail_vld;
    mem_req_t tail_req;
    mem_idx_t tail_idx;

    // ------------------------------------------------------------------------
    // Request pipeline
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < PIPE_DEPTH; s++) begin
                pipe_vld_q[s] <= 1'b0;
            end
        end else begin
            pipe_vld_q[0] <= req_valid_i;
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                pipe_vld_q[s] <= pipe_vld_q[s-1];
            end
        end
    end

    // Payload shift
    always_ff @(posedge clk_i) begin
        pipe_req_q[0] <= req_i;
        for (int s = 1; s < PIPE_DEPTH; s++) begin
            pipe_req_q[s] <= pipe_req_q[s-1];
        end
    end

    assign tail_vld = pipe_vld_q[PIPE_DEPTH-1];
    assign tail_req = pipe_req_q[PIPE_DEPTH-1];
    // Word address modulo MEM_WORDS
    assign tail_idx = tail_req.addr[2 +: MEM_IDX_W];

    // ------------------------------------------------------------------------
    // Array access at the last stage
    // ------------------------------------------------------------------------
    // Reads and writes hit the array in grant order
    always_ff @(posedge clk_i) begin
        if (tail_vld) begin
            if (tail_req.we) begin
                mem_q[tail_idx] <= tail_req.wdata;
            end
            // Write echoes its own data
            rsp_o.rdata <= tail_req.we ? tail_req.wdata : mem_q[tail_idx];
            rsp_o.src   <= tail_req.src;
        end
    end

    // Valid and credit strobes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
            credit_o    <= 1'b0;
        end else begin
            rsp_valid_o <= tail_vld;
            // Slot freed once the response has left
            credit_o    <= rsp_valid_o;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top import riscv_mem_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Core request ports
    input  port_vec_t                 core_req_valid_i,
    input  mem_req_t [NUM_PORTS-1:0]  core_req_i,
    output port_vec_t                 core_req_credit_o,
    // Core responses
    output port_vec_t                 core_rsp_valid_o,
    output mem_rsp_t                  core_rsp_o
);

    // Interconnect to controller
    logic     mc_req_valid;
    mem_req_t mc_req;
    logic     mc_credit;
    logic     mc_rsp_valid;
    mem_rsp_t mc_rsp;

    multi_core_interconnect u_interconnect (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .core_req_valid_i  (core_req_valid_i),
        .core_req_i        (core_req_i),
        .core_req_credit_o (core_req_credit_o),
        .mc_req_valid_o    (mc_req_valid),
        .mc_req_o          (mc_req),
        .mc_credit_i       (mc_credit),
        .mc_rsp_valid_i    (mc_rsp_valid),
        .mc_rsp_i          (mc_rsp),
        .core_rsp_valid_o  (core_rsp_valid_o),
        .core_rsp_o        (core_rsp_o)
    );

    mem_controller u_mem_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (mc_req_valid),
        .req_i       (mc_req),
        .credit_o    (mc_credit),
        .rsp_valid_o (mc_rsp_valid),
        .rsp_o       (mc_rsp)
    );

endmodule

`default_nettype wire

/* logic/multi_core_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

module multi_core_interconnect import riscv_mem_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Core request ports, I and D per core
    input  port_vec_t                 core_req_valid_i,
    input  mem_req_t [NUM_PORTS-1:0]  core_req_i,
    output port_vec_t                 core_req_credit_o,

    // Controller request channel
    output logic                      mc_req_valid_o,
    output mem_req_t                  mc_req_o,
    input  logic                      mc_credit_i,

    // Controller response channel
    input  logic                      mc_rsp_valid_i,
    input  mem_rsp_t                  mc_rsp_i,

    // Core responses, no back-pressure
    output port_vec_t                 core_rsp_valid_o,
    output mem_rsp_t                  core_rsp_o
);

    port_vec_t                fifo_empty;
    port_vec_t                fifo_pop;
    mem_req_t [NUM_PORTS-1:0] fifo_head;

    // ------------------------------------------------------------------------
    // Ingress buffers
    // ------------------------------------------------------------------------
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        req_ingress_fifo u_fifo (
            .clk_i      (clk_i),
            .rst_i      (rst_i),
            .push_i     (core_req_valid_i[p]),
            .push_req_i (core_req_i[p]),
            .pop_i      (fifo_pop[p]),
            .empty_o    (fifo_empty[p]),
            .head_o     (fifo_head[p]),
            .credit_o   (core_req_credit_o[p])
        );
    end

    // ------------------------------------------------------------------------
    // Arbitration onto the single controller channel
    // ------------------------------------------------------------------------
    rr_port_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .empty_i        (fifo_empty),
        .head_i         (fifo_head),
        .pop_o          (fifo_pop),
        .mc_credit_i    (mc_credit_i),
        .mc_req_valid_o (mc_req_valid_o),
        .mc_req_o       (mc_req_o)
    );

    // Responses back by source ID
    rsp_router u_router (
        .mc_rsp_valid_i   (mc_rsp_valid_i),
        .mc_rsp_i         (mc_rsp_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o)
    );

endmodule

`default_nettype wire

/* logic/req_ingress_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module req_ingress_fifo import riscv_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    // Core side
    input  logic     push_i,
    input  mem_req_t push_req_i,
    // Arbiter side
    input  logic     pop_i,
    output logic     empty_o,
    output mem_req_t head_o,
    // One pulse per drained entry
    output logic     credit_o
);

    // Storage, no reset on payload
    mem_req_t  entry_q [PORT_CREDITS];
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;
    fifo_cnt_t count_q;

    // Wrap at buffer depth
    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t p);
        if (p == fifo_ptr_t'(PORT_CREDITS - 1)) begin
            return '0;
        end
        return p + fifo_ptr_t'(1);
    endfunction

    // ------------------------------------------------------------------------
    // Pointers, fill count and credit return
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leaves count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + fifo_cnt_t'(1);
                2'b01:   count_q <= count_q - fifo_cnt_t'(1);
                default: count_q <= count_q;
            endcase
            // Registered, one cycle after the pop
            credit_o <= pop_i;
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entry_q[wr_ptr_q] <= push_req_i;
        end
    end

    // Head visible the cycle after the write
    assign head_o  = entry_q[rd_ptr_q];
    assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

/* logic/riscv_mem_pkg.sv */
`default_nettype none

package riscv_mem_pkg;

    // ------------------------------------------------------------------------
    // Cluster sizing
    // ------------------------------------------------------------------------
    localparam int NUM_CORES    = 2;
    // I-side and D-side miss port per core
    localparam int NUM_PORTS    = NUM_CORES * 2;
    localparam int PORT_CREDITS = 2;
    localparam int MC_CREDITS   = 4;
    localparam int MC_LATENCY   = 3;
    localparam int MEM_WORDS    = 256;

    // Derived widths
    localparam int SRC_W       = $clog2(NUM_PORTS);
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int FIFO_PTR_W  = $clog2(PORT_CREDITS);
    localparam int FIFO_CNT_W  = $clog2(PORT_CREDITS + 1);
    localparam int MC_CNT_W    = $clog2(MC_CREDITS + 1);

    typedef logic [31:0]            addr_t;
    typedef logic [31:0]            data_t;
    // Port number, core index * 2 + 1 for the data port
    typedef logic [SRC_W-1:0]       src_id_t;
    typedef logic [NUM_PORTS-1:0]   port_vec_t;
    typedef logic [MEM_IDX_W-1:0]   mem_idx_t;
    typedef logic [FIFO_PTR_W-1:0]  fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0]  fifo_cnt_t;
    typedef logic [MC_CNT_W-1:0]    mc_cnt_t;

    // Request toward memory
    typedef struct packed {
        addr_t   addr;
        data_t   wdata;
        logic    we;
        src_id_t src;
    } mem_req_t;

    // Response back to the issuing port, write data echoed on a write
    typedef struct packed {
        data_t   rdata;
        src_id_t src;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* logic/rr_port_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_port_arbiter import riscv_mem_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Ingress buffers
    input  port_vec_t                 empty_i,
    input  mem_req_t [NUM_PORTS-1:0]  head_i,
    output port_vec_t                 pop_o,
    // Controller channel
    input  logic                      mc_credit_i,
    output logic                      mc_req_valid_o,
    output mem_req_t                  mc_req_o
);

    // Last granted port, rotation starts after it
    src_id_t last_q;
    // Controller slots still free
    mc_cnt_t credit_cnt_q;

    logic    grant;
    src_id_t grant_idx;

    // ------------------------------------------------------------------------
    // Round-robin pick
    // ------------------------------------------------------------------------
    always_comb begin
        int      sum;
        src_id_t cand;
        grant     = 1'b0;
        grant_idx = last_q;
        sum       = 0;
        cand      = '0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            sum = int'(last_q) + k;
            if (sum >= NUM_PORTS) begin
                sum = sum - NUM_PORTS;
            end
            cand = src_id_t'(sum);
            // First non-empty port wins
            if (!grant && !empty_i[cand]) begin
                grant     = 1'b1;
                grant_idx = cand;
            end
        end
        // No slot downstream, hold everything
        if (credit_cnt_q == '0) begin
            grant = 1'b0;
        end
    end

    // Pop in the grant cycle
    always_comb begin
        pop_o = '0;
        pop_o[grant_idx] = grant;
    end

    // ------------------------------------------------------------------------
    // Credit counter, rotation state, request register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_q         <= src_id_t'(NUM_PORTS - 1);
            credit_cnt_q   <= mc_cnt_t'(MC_CREDITS);
            mc_req_valid_o <= 1'b0;
        end else begin
            if (grant) begin
                last_q <= grant_idx;
            end
            case ({grant, mc_credit_i})
                2'b10:   credit_cnt_q <= credit_cnt_q - mc_cnt_t'(1);
                2'b01:   credit_cnt_q <= credit_cnt_q + mc_cnt_t'(1);
                default: credit_cnt_q <= credit_cnt_q;
            endcase
            mc_req_valid_o <= grant;
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (grant) begin
            mc_req_o <= head_i[grant_idx];
        end
    end

endmodule

`default_nettype wire

/* logic/rsp_router.sv */
`timescale 1ns/1ps
`default_nettype none

module rsp_router import riscv_mem_pkg::*; (
    // From the controller
    input  logic      mc_rsp_valid_i,
    input  mem_rsp_t  mc_rsp_i,
    // To the cores
    output port_vec_t core_rsp_valid_o,
    output mem_rsp_t  core_rsp_o
);

    // ------------------------------------------------------------------------
    // Source ID decode
    // ------------------------------------------------------------------------
    port_vec_t src_hit;

    // One-hot match of the returning ID
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            src_hit[p] = (mc_rsp_i.src == src_id_t'(p));
        end
    end

    // Only the issuing port sees valid
    assign core_rsp_valid_o = src_hit & {NUM_PORTS{mc_rsp_valid_i}};

    // Payload broadcast to every port
    assign core_rsp_o = mc_rsp_i;

endmodule

`default_nettype wire

/* verif/mem_subsystem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_checker import riscv_mem_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  port_vec_t push_i,
    input  port_vec_t pop_i,
    input  logic      mc_credit_i,
    input  logic      mc_req_valid_i,
    input  logic      mc_rsp_valid_i,
    input  port_vec_t core_rsp_valid_i
);

    // Shadow fill levels, in-flight counts and controller credits
    int        fill_q [NUM_PORTS];
    int        flight_q [NUM_PORTS];
    int        credit_q;
    port_vec_t full_push;
    // Ports with no granted request awaiting its response
    port_vec_t idle_port;
    // Failed assertions so far
    int        fail_cnt = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                fill_q[p]   <= 0;
                flight_q[p] <= 0;
            end
            credit_q <= MC_CREDITS;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                fill_q[p]   <= fill_q[p] + int'(push_i[p]) - int'(pop_i[p]);
                // Granted when popped, done when its response comes back
                flight_q[p] <= flight_q[p] + int'(pop_i[p]) - int'(core_rsp_valid_i[p]);
            end
            // One grant per cycle at most
            credit_q <= credit_q - int'(|pop_i) + int'(mc_credit_i);
        end
    end

    // Push into a buffer that already holds PORT_CREDITS entries
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            full_push[p] = push_i[p] && (fill_q[p] >= PORT_CREDITS);
            idle_port[p] = (flight_q[p] == 0);
        end
    end

    // ------------------------------------------------------------------------
    // Protocol properties
    // ------------------------------------------------------------------------
    no_full_push: assert property (@(posedge clk_i) disable iff (rst_i)
        full_push == '0)
        else begin
            fail_cnt++;
            $error("ingress buffer pushed while full");
        end

    credit_range: assert property (@(posedge clk_i) disable iff (rst_i)
        credit_q >= 0 && credit_q <= MC_CREDITS)
        else begin
            fail_cnt++;
            $error("arbiter credit count out of range: %0d", credit_q);
        end

    // Valid follows its grant by one cycle
    valid_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        mc_req_valid_i |-> $past(credit_q) > 0)
        else begin
            fail_cnt++;
            $error("controller request issued without a credit");
        end

    // Routed to exactly one port that has a request in flight
    rsp_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        mc_rsp_valid_i |-> $onehot(core_rsp_valid_i) && ((core_rsp_valid_i & idle_port) == '0))
        else begin
            fail_cnt++;
            $error("response not routed to exactly one port with a request in flight");
        end

endmodule

`default_nettype wire

/* verif/tb_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard import riscv_mem_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    // Core side of the DUT
    input  port_vec_t                req_valid_i,
    input  mem_req_t [NUM_PORTS-1:0] req_i,
    input  port_vec_t                credit_i,
    input  port_vec_t                rsp_valid_i,
    input  mem_rsp_t                 rsp_i,
    // Test control
    input  logic                     fair_en_i,
    input  logic                     drain_chk_i,
    output int                       err_cnt_o,
    output int                       chk_cnt_o,
    output int                       pending_o
);

    // Word offset inside one port's region
    localparam int OFF_W = MEM_IDX_W - SRC_W;

    // Name of the running test, written from the top
    string test_name = "idle";

    // Per-port memory image and expected responses
    data_t model_mem [NUM_PORTS][2**OFF_W];
    data_t exp_q     [NUM_PORTS][$];
    // Buffered entries still owed a credit
    int    debt      [NUM_PORTS];
    // Responses to the column port since the row port's last one
    int    since     [NUM_PORTS][NUM_PORTS];
    int    req_total = 0;
    int    rsp_total = 0;
    int    err_cnt   = 0;
    int    chk_cnt   = 0;
    int    pending   = 0;

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;
    assign pending_o = pending;

    task automatic report_value(input string what, input data_t exp_v, input data_t act_v);
        err_cnt++;
        $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    endtask

    task automatic report_other(input string msg);
        err_cnt++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    // ------------------------------------------------------------------------
    // One response on port p
    // ------------------------------------------------------------------------
    task automatic check_rsp(input int p);
        data_t exp_d;
        rsp_total++;
        chk_cnt++;
        if (exp_q[p].size() == 0) begin
            report_other($sformatf("port %0d got a response with nothing outstanding", p));
            return;
        end
        exp_d = exp_q[p].pop_front();
        pending--;
        if (rsp_i.rdata !== exp_d) begin
            report_value($sformatf("port %0d data", p), exp_d, rsp_i.rdata);
        end
        if (rsp_i.src !== src_id_t'(p)) begin
            report_value($sformatf("port %0d source", p), data_t'(p), data_t'(rsp_i.src));
        end
        // Fairness window bookkeeping
        for (int q = 0; q < NUM_PORTS; q++) begin
            if (q != p) begin
                since[q][p]++;
                if (fair_en_i && since[q][p] > 1) begin
                    report_other($sformatf("port %0d served twice between two on port %0d",
                                           p, q));
                end
            end
            since[p][q] = 0;
        end
    endtask

    // Everything is stable at the falling edge
    always @(negedge clk_i) begin : sample
        int off;
        if (rst_i) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                exp_q[p].delete();
                debt[p] = 0;
            end
            pending = 0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (credit_i[p]) begin
                    if (debt[p] == 0) begin
                        report_other($sformatf("port %0d returned a credit it did not owe", p));
                    end else begin
                        debt[p]--;
                    end
                end
                if (req_valid_i[p]) begin
                    off = int'(req_i[p].addr[2 +: OFF_W]);
                    // Write echoes its own data
                    if (req_i[p].we) begin
                        model_mem[p][off] = req_i[p].wdata;
                    end
                    exp_q[p].push_back(model_mem[p][off]);
                    debt[p]++;
                    req_total++;
                    pending++;
                end
                if (rsp_valid_i[p]) begin
                    check_rsp(p);
                end
            end
            if (!fair_en_i) begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    for (int q = 0; q < NUM_PORTS; q++) begin
                        since[p][q] = 0;
                    end
                end
            end
            // Quiet system, counts must balance
            if (drain_chk_i) begin
                chk_cnt++;
                if (rsp_total != req_total) begin
                    err_cnt++;
                    $display("FAIL %s response count: expected %0d, actual %0d",
                             test_name, req_total, rsp_total);
                end
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (debt[p] != 0) begin
                        err_cnt++;
                        $display("FAIL %s port %0d credits owed: expected 0, actual %0d",
                                 test_name, p, debt[p]);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import riscv_mem_pkg::*; ();

    typedef enum int {
        MODE_WRITE_SEQ,
        MODE_READ_SEQ,
        MODE_FILL,
        MODE_RANDOM,
        MODE_STREAM
    } traffic_mode_e;

    localparam int OFF_W        = MEM_IDX_W - SRC_W;
    localparam int UPPER_W      = 30 - MEM_IDX_W;
    localparam int REGION_WORDS = MEM_WORDS / NUM_PORTS;
    localparam int SEQ_WORDS    = 8;
    localparam int RAND_REQS    = 60;
    localparam int BURST_ROUNDS = 5;
    localparam int FAIR_REQS    = 20;
    // Requests over all tests
    localparam int TOTAL_REQS   = 2 * SEQ_WORDS + NUM_PORTS * (REGION_WORDS + RAND_REQS
                                  + BURST_ROUNDS * PORT_CREDITS + FAIR_REQS);
    localparam int CYCLE_LIMIT  = 20 * TOTAL_REQS + 200;

    logic                     clk;
    logic                     rst;
    port_vec_t                core_req_valid;
    mem_req_t [NUM_PORTS-1:0] core_req;
    port_vec_t                core_req_credit;
    port_vec_t                core_rsp_valid;
    mem_rsp_t                 core_rsp;
    logic                     fair_en;
    logic                     drain_chk;
    int                       err_cnt;
    int                       chk_cnt;
    int                       pending;

    // Core-side credit counters
    int    credits [NUM_PORTS];
    int    seed      = 22;
    int    cycle_cnt = 0;
    int    err_at_start;
    int    tests_ok  = 0;
    int    tests_bad = 0;
    string cur_test  = "reset";

    mem_subsystem_top u_dut (
        .clk_i             (clk),
        .rst_i             (rst),
        .core_req_valid_i  (core_req_valid),
        .core_req_i        (core_req),
        .core_req_credit_o (core_req_credit),
        .core_rsp_valid_o  (core_rsp_valid),
        .core_rsp_o        (core_rsp)
    );

    tb_scoreboard u_scoreboard (
        .clk_i       (clk),
        .rst_i       (rst),
        .req_valid_i (core_req_valid),
        .req_i       (core_req),
        .credit_i    (core_req_credit),
        .rsp_valid_i (core_rsp_valid),
        .rsp_i       (core_rsp),
        .fair_en_i   (fair_en),
        .drain_chk_i (drain_chk),
        .err_cnt_o   (err_cnt),
        .chk_cnt_o   (chk_cnt),
        .pending_o   (pending)
    );

    bind multi_core_interconnect mem_subsystem_checker u_checker (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .push_i           (core_req_valid_i),
        .pop_i            (fifo_pop),
        .mc_credit_i      (mc_credit_i),
        .mc_req_valid_i   (mc_req_valid_o),
        .mc_rsp_valid_i   (mc_rsp_valid_i),
        .core_rsp_valid_i (core_rsp_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Run limit
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt > CYCLE_LIMIT);
        $display("timeout in %s: traffic did not drain within %0d cycles", cur_test, CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    function automatic int total_errors();
        return err_cnt + u_dut.u_interconnect.u_checker.fail_cnt;
    endfunction

    // Depends on every address bit
    function automatic data_t fill_word(input addr_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    // Word index top bits carry the port number
    function automatic mem_req_t make_req(input int p, input int idx, input traffic_mode_e mode);
        mem_req_t             r;
        logic [OFF_W-1:0]     off;
        logic [UPPER_W-1:0]   upper;
        r.src   = src_id_t'(p);
        r.we    = (mode != MODE_READ_SEQ);
        r.wdata = $random(seed);
        off     = idx[OFF_W-1:0];
        upper   = '0;
        if (mode == MODE_RANDOM || mode == MODE_STREAM) begin
            r.we  = (($random(seed) & 1) == 1);
            off   = OFF_W'($random(seed));
            // Above the array, wraps modulo MEM_WORDS
            upper = UPPER_W'($random(seed));
        end
        r.addr = {upper, src_id_t'(p), off, 2'b00};
        if (mode == MODE_FILL) begin
            r.wdata = fill_word(r.addr);
        end
        return r;
    endfunction

    // Next cycle, 1 ns past the edge, credits collected
    task automatic tick();
        @(posedge clk);
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            credits[p] += int'(core_req_credit[p]);
        end
    endtask

    task automatic run_traffic(input port_vec_t mask, input int count, input traffic_mode_e mode);
        int   sent [NUM_PORTS];
        logic busy;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sent[p] = 0;
        end
        busy = 1'b1;
        while (busy) begin
            tick();
            busy = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                core_req_valid[p] = 1'b0;
                if (mask[p] && sent[p] < count) begin
                    busy = 1'b1;
                    // Random mode sends about every other cycle
                    if (credits[p] > 0 &&
                        (mode != MODE_RANDOM || (($random(seed) & 1) == 1))) begin
                        core_req[p]       = make_req(p, sent[p], mode);
                        core_req_valid[p] = 1'b1;
                        credits[p]--;
                        sent[p]++;
                    end
                end
            end
        end
    endtask

    // All credits home and no response outstanding
    task automatic wait_drain();
        logic done;
        done = 1'b0;
        while (!done) begin
            tick();
            done = (pending == 0);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (credits[p] < PORT_CREDITS) begin
                    done = 1'b0;
                end
            end
        end
        drain_chk = 1'b1;
        tick();
        drain_chk = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test               = name;
        u_scoreboard.test_name = name;
        err_at_start           = total_errors();
    endtask

    task automatic end_test();
        int errs;
        errs = total_errors() - err_at_start;
        if (errs == 0) begin
            tests_ok++;
            $display("test %s: done, no errors", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: done, %0d error(s)", cur_test, errs);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        rst            = 1'b1;
        core_req_valid = '0;
        core_req       = '0;
        fair_en        = 1'b0;
        drain_chk      = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            credits[p] = PORT_CREDITS;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Stray credits or responses flagged by the scoreboard
        begin_test("reset_idle");
        repeat (10) tick();
        end_test();

        begin_test("single_port");
        run_traffic(port_vec_t'(1), SEQ_WORDS, MODE_WRITE_SEQ);
        run_traffic(port_vec_t'(1), SEQ_WORDS, MODE_READ_SEQ);
        wait_drain();
        end_test();

        // Region fill first so every read hits known data
        begin_test("random_traffic");
        run_traffic('1, REGION_WORDS, MODE_FILL);
        run_traffic('1, RAND_REQS, MODE_RANDOM);
        wait_drain();
        end_test();

        begin_test("credit_burst");
        repeat (BURST_ROUNDS) begin
            run_traffic('1, PORT_CREDITS, MODE_STREAM);
            wait_drain();
        end
        end_test();

        begin_test("rr_fairness");
        fair_en = 1'b1;
        run_traffic('1, FAIR_REQS, MODE_STREAM);
        wait_drain();
        fair_en = 1'b0;
        end_test();

        $display("summary: %0d tests clean, %0d with errors, %0d checks, %0d errors",
                 tests_ok, tests_bad, chk_cnt, total_errors());
        if (tests_bad == 0 && total_errors() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/riscv_mem_pkg.sv
logic/req_ingress_fifo.sv
logic/rr_port_arbiter.sv
logic/rsp_router.sv
logic/multi_core_interconnect.sv
logic/mem_controller.sv
logic/mem_subsystem_top.sv
verif/mem_subsystem_checker.sv
verif/tb_scoreboard.sv
verif/tb_top.sv
